// ==== rtl/switch_pkg.sv ====
`default_nettype none

package switch_pkg;

	////////////////////
	// Bus addresses
	////////////////////

	typedef logic [7:0] bus_addr_t;

	// Write side
	localparam bus_addr_t wr_io_pin_sw      = 8'h40;
	localparam bus_addr_t wr_self_test_sw   = 8'h41;
	localparam bus_addr_t wr_loopback_mux   = 8'h43;
	localparam bus_addr_t wr_anlg_in_b1_sw  = 8'h44;

	// Read side
	localparam bus_addr_t rd_io_pin_sw      = 8'hc0;
	localparam bus_addr_t rd_self_test_sw   = 8'hc1;
	localparam bus_addr_t rd_loopback_mux   = 8'hc3;
	localparam bus_addr_t rd_anlg_in_b1_sw  = 8'hc4;

	////////////////////
	// Switch groups
	////////////////////

	// One bit per pin switch, 1 is closed at the logical level
	typedef logic [11:0] io_pin_sw_t;

	// Bit 0 diff loopback, 3:1 loop switches, 7:4 DC voltage one-hot set
	typedef logic [7:0] self_test_sw_t;

	// 8:1 analog mux, enable on top
	typedef struct packed {
		logic       en;
		logic [2:0] addr;
	} mux_sel_t;

	// Analog input B1, one-hot
	typedef logic [3:0] b1_sw_t;

	////////////////////
	// Bus word views
	////////////////////

	typedef struct packed {
		logic [3:0] pad;
		io_pin_sw_t sw;
	} io_pin_word_t;

	typedef struct packed {
		logic [7:0]    pad;
		self_test_sw_t sw;
	} self_test_word_t;

	typedef struct packed {
		logic [11:0] pad;
		mux_sel_t    sel;
	} mux_word_t;

	typedef struct packed {
		logic [11:0] pad;
		b1_sw_t      sw;
	} b1_word_t;

	// Layout depends on the bus address
	typedef union packed {
		io_pin_word_t    io_pin;
		self_test_word_t self_test;
		mux_word_t       mux;
		b1_word_t        b1;
	} bus_word_u;

	////////////////////
	// Bundles between stages
	////////////////////

	// Requested settings as latched from the bus
	typedef struct packed {
		io_pin_sw_t    io_pin;
		self_test_sw_t self_test;
		mux_sel_t      mux;
		b1_sw_t        b1;
	} switch_req_t;

	// One cycle strobes, one per written group
	typedef struct packed {
		logic io_pin;
		logic self_test;
		logic mux;
		logic b1;
	} switch_change_t;

	// Applied logical state, pin inversion not yet done
	typedef struct packed {
		io_pin_sw_t    io_pin;
		self_test_sw_t self_test;
		mux_sel_t      mux;
		b1_sw_t        b1;
	} switch_state_t;

endpackage

`default_nettype wire

// ==== rtl/bus_write_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_write_decode (
	input  wire                     xclk,
	input  wire                     reset,
	input  wire                     write_qualified,
	input  switch_pkg::bus_addr_t   ab,
	input  switch_pkg::bus_word_u   db_in,
	output switch_pkg::switch_req_t    req,
	output switch_pkg::switch_change_t change
);

	import switch_pkg::*;

	////////////////////
	// Request latches
	////////////////////

	// Each address owns one field of the request
	// The union view picks the bits that field needs
	// Strobes fall back to 0 on every edge without a matching write
	always_ff @(posedge xclk or negedge reset) begin
		if (!reset) begin
			req    <= '0;
			change <= '0;
		end else begin
			// Default is no change this cycle
			change <= '0;
			if (write_qualified) begin
				case (ab)
					wr_io_pin_sw: begin
						req.io_pin    <= db_in.io_pin.sw;
						change.io_pin <= 1'b1;
					end
					wr_self_test_sw: begin
						req.self_test    <= db_in.self_test.sw;
						change.self_test <= 1'b1;
					end
					wr_loopback_mux: begin
						req.mux    <= db_in.mux.sel;
						change.mux <= 1'b1;
					end
					wr_anlg_in_b1_sw: begin
						req.b1    <= db_in.b1.sw;
						change.b1 <= 1'b1;
					end
					default: begin
						// Unknown address, nothing is touched
						req <= req;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/one_hot_bbm.sv ====
`timescale 1ns/1ps
`default_nettype none

module one_hot_bbm #(
	parameter int width         = 4,
	parameter int settle_cycles = 3750
) (
	input  wire              xclk,
	input  wire              reset,
	input  wire              change,
	input  wire  [width-1:0] request,
	output logic [width-1:0] applied
);

	// Counter just wide enough to reach the settle value
	localparam int cnt_w = (settle_cycles < 1) ? 1 : $clog2(settle_cycles + 1);

	logic [width-1:0] pending;
	logic [width-1:0] lowest;
	logic [cnt_w-1:0] count;

	// Keep only the lowest set bit of the pending value
	// Two's complement trick isolates that bit
	assign lowest = pending & (~pending + 1'b1);

	////////////////////
	// Break before make
	////////////////////

	// New request opens every switch and restarts the wait
	// Counter saturates and then keeps loading the pending value
	always_ff @(posedge xclk or negedge reset) begin
		if (!reset) begin
			applied <= '0;
			pending <= '0;
			count   <= '0;
		end else if (change) begin
			applied <= '0;
			pending <= request;
			count   <= '0;
		end else if (count == cnt_w'(settle_cycles)) begin
			applied <= lowest;
		end else begin
			count <= count + 1'b1;
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Never two switches of the group closed at once
	a_applied_onehot: assert property (@(posedge xclk) disable iff (!reset)
		$onehot0(applied))
		else $error("one_hot_bbm closed more than one switch");

endmodule

`default_nettype wire

// ==== rtl/exclusive_pair_bbm.sv ====
`timescale 1ns/1ps
`default_nettype none

module exclusive_pair_bbm #(
	parameter int width_a       = 1,
	parameter int settle_cycles = 3750
) (
	input  wire                xclk,
	input  wire                reset,
	input  wire                change_a,
	input  wire                change_b,
	input  wire  [width_a-1:0] request_a,
	input  wire                request_b,
	output logic [width_a-1:0] applied_a,
	output logic               applied_b
);

	localparam int cnt_w = (settle_cycles < 1) ? 1 : $clog2(settle_cycles + 1);

	// Applied and pending state for each side
	logic [width_a-1:0] set_a;
	logic [width_a-1:0] pend_a;
	logic               set_b;
	logic               pend_b;

	// One settle counter serves both sides
	logic [cnt_w-1:0]   count;

	////////////////////
	// Pair control
	////////////////////

	// Side A request with any bit set
	//   open both sides, drop B, wait again
	// Side B request set
	//   same in mirror
	// Request that clears a side only drops that side's pending value
	always_ff @(posedge xclk or negedge reset) begin
		if (!reset) begin
			set_a  <= '0;
			pend_a <= '0;
			set_b  <= 1'b0;
			pend_b <= 1'b0;
			count  <= '0;
		end else if (change_a) begin
			if (|request_a) begin
				set_a  <= '0;
				set_b  <= 1'b0;
				pend_a <= request_a;
				pend_b <= 1'b0;
				count  <= '0;
			end else begin
				pend_a <= '0;
			end
		end else if (change_b) begin
			if (request_b) begin
				set_a  <= '0;
				set_b  <= 1'b0;
				pend_a <= '0;
				pend_b <= 1'b1;
				count  <= '0;
			end else begin
				pend_b <= 1'b0;
			end
		end else if (count == cnt_w'(settle_cycles)) begin
			// Settled, keep loading the pending values
			set_a <= pend_a;
			set_b <= pend_b;
		end else begin
			count <= count + 1'b1;
		end
	end

	////////////////////
	// Outputs
	////////////////////

	assign applied_a = set_a;
	// Side A wins if both ever end up set
	assign applied_b = set_b & ~(|set_a);

	// Both applied registers never loaded closed together
	a_pair_exclusive: assert property (@(posedge xclk) disable iff (!reset)
		!(set_b && (|set_a)))
		else $error("exclusive_pair_bbm closed both sides");

endmodule

`default_nettype wire

// ==== rtl/switch_readback.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_readback (
	input  wire                      xclk,
	input  wire                      reset,
	input  wire                      read_qualified,
	input  switch_pkg::bus_addr_t    ab,
	input  switch_pkg::switch_req_t  req,
	input  switch_pkg::b1_sw_t       b1_applied,
	input  wire  [3:0]               st_dc_applied,
	input  wire                      pin6_applied,
	input  wire                      mux_en_applied,
	input  wire  [1:0]               diff_pins_applied,
	input  wire                      diff_loop_applied,
	output logic [11:0]              io_pin_switches,
	output logic [7:0]               self_test_switches,
	output logic [3:0]               loopback_mux,
	output logic [3:0]               anlg_in_b1_switches,
	output logic [15:0]              db_out,
	output logic                     data_avail
);

	import switch_pkg::*;

	switch_state_t state;
	bus_word_u     rd_word;
	bus_word_u     db_q;
	logic          rd_hit;

	////////////////////
	// Applied state
	////////////////////

	// Unprotected bits come straight from the request
	always_comb begin
		state.io_pin        = req.io_pin;
		state.io_pin[6]     = pin6_applied;
		state.io_pin[11:10] = diff_pins_applied;
		state.self_test     = {st_dc_applied, req.self_test[3:1], diff_loop_applied};
		state.mux.en        = mux_en_applied;
		state.mux.addr      = req.mux.addr;
		state.b1            = b1_applied;
	end

	// Pins 0 to 2 are driven inverted
	assign io_pin_switches     = {state.io_pin[11:3], ~state.io_pin[2:0]};
	assign self_test_switches  = state.self_test;
	assign loopback_mux        = state.mux;
	assign anlg_in_b1_switches = state.b1;

	////////////////////
	// Readback
	////////////////////

	// Logical state, pads zero, all ones for an unknown address
	always_comb begin
		rd_word = '1;
		rd_hit  = 1'b0;
		case (ab)
			rd_io_pin_sw: begin
				rd_word           = '0;
				rd_word.io_pin.sw = state.io_pin;
				rd_hit            = 1'b1;
			end
			rd_self_test_sw: begin
				rd_word              = '0;
				rd_word.self_test.sw = state.self_test;
				rd_hit               = 1'b1;
			end
			rd_loopback_mux: begin
				rd_word         = '0;
				rd_word.mux.sel = state.mux;
				rd_hit          = 1'b1;
			end
			rd_anlg_in_b1_sw: begin
				rd_word       = '0;
				rd_word.b1.sw = state.b1;
				rd_hit        = 1'b1;
			end
			default: begin
				rd_hit = 1'b0;
			end
		endcase
	end

	// Held until the next qualified read
	always_ff @(posedge xclk or negedge reset) begin
		if (!reset) begin
			db_q       <= '0;
			data_avail <= 1'b0;
		end else if (read_qualified) begin
			db_q       <= rd_word;
			data_avail <= rd_hit;
		end
	end

	assign db_out = db_q;

	// Top nibble is pad in every view
	a_pad_zero: assert property (@(posedge xclk) disable iff (!reset)
		data_avail |-> (db_q.io_pin.pad == '0))
		else $error("switch_readback returned nonzero pad bits");

endmodule

`default_nettype wire

// ==== rtl/switch_app_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_app_top #(
	parameter int settle_cycles = 3750
) (
	input  wire                    xclk,
	input  wire                    reset,
	input  wire                    write_qualified,
	input  wire                    read_qualified,
	input  switch_pkg::bus_addr_t  ab,
	input  switch_pkg::bus_word_u  db_in,
	output logic [15:0]            db_out,
	output logic                   data_avail,
	output logic [11:0]            io_pin_switches,
	output logic [7:0]             self_test_switches,
	output logic [3:0]             loopback_mux,
	output logic [3:0]             anlg_in_b1_switches
);

	import switch_pkg::*;

	switch_req_t    req;
	switch_change_t change;

	// Protected bits after break before make
	b1_sw_t         b1_applied;
	logic [3:0]     st_dc_applied;
	logic           pin6_applied;
	logic           mux_en_applied;
	logic [1:0]     diff_pins_applied;
	logic           diff_loop_applied;

	////////////////////
	// Decode
	////////////////////

	bus_write_decode decode0 (
		.xclk            (xclk),
		.reset           (reset),
		.write_qualified (write_qualified),
		.ab              (ab),
		.db_in           (db_in),
		.req             (req),
		.change          (change)
	);

	////////////////////
	// Execute
	////////////////////

	// Analog input B1, one of four
	one_hot_bbm #(.width(4), .settle_cycles(settle_cycles)) b1_group (
		.xclk    (xclk),
		.reset   (reset),
		.change  (change.b1),
		.request (req.b1),
		.applied (b1_applied)
	);

	// Self-test DC voltage switches 7:4
	one_hot_bbm #(.width(4), .settle_cycles(settle_cycles)) st_dc_group (
		.xclk    (xclk),
		.reset   (reset),
		.change  (change.self_test),
		.request (req.self_test[7:4]),
		.applied (st_dc_applied)
	);

	// Analog in pin 6 against mux enable
	exclusive_pair_bbm #(.width_a(1), .settle_cycles(settle_cycles)) mux_pin_pair (
		.xclk      (xclk),
		.reset     (reset),
		.change_a  (change.io_pin),
		.change_b  (change.mux),
		.request_a (req.io_pin[6]),
		.request_b (req.mux.en),
		.applied_a (pin6_applied),
		.applied_b (mux_en_applied)
	);

	// Diff pins 10 and 11 against diff loopback
	exclusive_pair_bbm #(.width_a(2), .settle_cycles(settle_cycles)) diff_pair (
		.xclk      (xclk),
		.reset     (reset),
		.change_a  (change.io_pin),
		.change_b  (change.self_test),
		.request_a (req.io_pin[11:10]),
		.request_b (req.self_test[0]),
		.applied_a (diff_pins_applied),
		.applied_b (diff_loop_applied)
	);

	////////////////////
	// Result
	////////////////////

	switch_readback readback0 (
		.xclk                (xclk),
		.reset               (reset),
		.read_qualified      (read_qualified),
		.ab                  (ab),
		.req                 (req),
		.b1_applied          (b1_applied),
		.st_dc_applied       (st_dc_applied),
		.pin6_applied        (pin6_applied),
		.mux_en_applied      (mux_en_applied),
		.diff_pins_applied   (diff_pins_applied),
		.diff_loop_applied   (diff_loop_applied),
		.io_pin_switches     (io_pin_switches),
		.self_test_switches  (self_test_switches),
		.loopback_mux        (loopback_mux),
		.anlg_in_b1_switches (anlg_in_b1_switches),
		.db_out              (db_out),
		.data_avail          (data_avail)
	);

endmodule

`default_nettype wire

// ==== verification/switch_app_cases.svh ====
`ifndef SWITCH_APP_CASES_SVH
`define SWITCH_APP_CASES_SVH

// op, addr, data, rnd, hold, then expected io, st, mux, b1, db_out, data_avail
// flags 0 b1 out, 1 st 7:4 out, 2 db 3:0, 3 db 7:4 take the lowest random bit
localparam int num_cases = 32;
localparam case_row_t cases [num_cases] = '{
	'{op_idle,  8'h00, 16'h0000, rnd_none, 8'd2, 12'h007, 8'h00, 4'h0, 4'h0, 16'h0000, 1'b0, 4'h0},
	'{op_write, 8'h40, 16'hf3a5, rnd_none, 8'd2, 12'h3a2, 8'h00, 4'h0, 4'h0, 16'h0000, 1'b0, 4'h0},
	'{op_write, 8'h41, 16'hab0e, rnd_none, 8'd2, 12'h3a2, 8'h0e, 4'h0, 4'h0, 16'h0000, 1'b0, 4'h0},
	'{op_write, 8'h43, 16'h0005, rnd_none, 8'd2, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h0000, 1'b0, 4'h0},
	'{op_read,  8'hc0, 16'h0000, rnd_none, 8'd1, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h03a5, 1'b1, 4'h0},
	'{op_read,  8'hc1, 16'h0000, rnd_none, 8'd1, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h000e, 1'b1, 4'h0},
	'{op_read,  8'hc3, 16'h0000, rnd_none, 8'd1, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h0005, 1'b1, 4'h0},
	'{op_read,  8'hc4, 16'h0000, rnd_none, 8'd1, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h0000, 1'b1, 4'h0},
	// Random B1 request, all off first, then lowest bit
	'{op_write, 8'h44, 16'h0000, rnd_b1, short_wait, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h0000, 1'b1, 4'h0},
	'{op_idle,  8'h00, 16'h0000, rnd_none, long_wait, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h0000, 1'b1, 4'h1},
	'{op_read,  8'hc4, 16'h0000, rnd_none, 8'd1, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h0000, 1'b1, 4'h5},
	'{op_write, 8'h44, 16'h0000, rnd_none, short_wait, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h0000, 1'b1, 4'h4},
	// Random DC group in self-test 7:4
	'{op_write, 8'h41, 16'h000e, rnd_st, short_wait, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h0000, 1'b1, 4'h4},
	'{op_idle,  8'h00, 16'h0000, rnd_none, long_wait, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h0000, 1'b1, 4'h6},
	'{op_read,  8'hc1, 16'h0000, rnd_none, 8'd1, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h000e, 1'b1, 4'ha},
	'{op_write, 8'h41, 16'h000e, rnd_none, long_wait, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h000e, 1'b1, 4'h8},
	// Pin 6 against mux enable
	'{op_write, 8'h40, 16'h03e5, rnd_none, long_wait, 12'h3e2, 8'h0e, 4'h5, 4'h0, 16'h000e, 1'b1, 4'h8},
	'{op_write, 8'h43, 16'h000d, rnd_none, short_wait, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h000e, 1'b1, 4'h8},
	'{op_idle,  8'h00, 16'h0000, rnd_none, long_wait, 12'h3a2, 8'h0e, 4'hd, 4'h0, 16'h000e, 1'b1, 4'h8},
	'{op_read,  8'hc3, 16'h0000, rnd_none, 8'd1, 12'h3a2, 8'h0e, 4'hd, 4'h0, 16'h000d, 1'b1, 4'h0},
	'{op_write, 8'h40, 16'h03e5, rnd_none, short_wait, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h000d, 1'b1, 4'h0},
	'{op_idle,  8'h00, 16'h0000, rnd_none, long_wait, 12'h3e2, 8'h0e, 4'h5, 4'h0, 16'h000d, 1'b1, 4'h0},
	'{op_read,  8'hc0, 16'h0000, rnd_none, 8'd1, 12'h3e2, 8'h0e, 4'h5, 4'h0, 16'h03e5, 1'b1, 4'h0},
	// Diff pins 10 and 11 against diff loopback
	'{op_write, 8'h41, 16'h000f, rnd_none, long_wait, 12'h3e2, 8'h0f, 4'h5, 4'h0, 16'h03e5, 1'b1, 4'h0},
	'{op_write, 8'h40, 16'h0fe5, rnd_none, short_wait, 12'h3a2, 8'h0e, 4'h5, 4'h0, 16'h03e5, 1'b1, 4'h0},
	'{op_idle,  8'h00, 16'h0000, rnd_none, long_wait, 12'hfe2, 8'h0e, 4'h5, 4'h0, 16'h03e5, 1'b1, 4'h0},
	'{op_write, 8'h41, 16'h000f, rnd_none, short_wait, 12'h3e2, 8'h0e, 4'h5, 4'h0, 16'h03e5, 1'b1, 4'h0},
	'{op_idle,  8'h00, 16'h0000, rnd_none, long_wait, 12'h3e2, 8'h0f, 4'h5, 4'h0, 16'h03e5, 1'b1, 4'h0},
	'{op_read,  8'hc1, 16'h0000, rnd_none, 8'd1, 12'h3e2, 8'h0f, 4'h5, 4'h0, 16'h000f, 1'b1, 4'h0},
	// Unknown addresses
	'{op_read,  8'h77, 16'h0000, rnd_none, 8'd1, 12'h3e2, 8'h0f, 4'h5, 4'h0, 16'hffff, 1'b0, 4'h0},
	'{op_write, 8'h55, 16'hffff, rnd_none, long_wait, 12'h3e2, 8'h0f, 4'h5, 4'h0, 16'hffff, 1'b0, 4'h0},
	'{op_read,  8'hc0, 16'h0000, rnd_none, 8'd1, 12'h3e2, 8'h0f, 4'h5, 4'h0, 16'h03e5, 1'b1, 4'h0}
};

`endif

// ==== verification/switch_app_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_app_tb;

	import switch_pkg::*;

	// Short settle time for simulation
	localparam int settle_cycles = 10;

	// Row waits in clock cycles after the bus edge
	localparam logic [7:0] short_wait = 8'd3;
	localparam logic [7:0] long_wait  = 8'(settle_cycles + 6);

	typedef enum logic [1:0] {op_idle, op_write, op_read} op_t;
	typedef enum logic [1:0] {rnd_none, rnd_b1, rnd_st} rnd_t;

	// One table row, stimulus then expected outputs
	typedef struct packed {
		op_t         op;
		bus_addr_t   addr;
		logic [15:0] data;
		rnd_t        rnd;
		logic [7:0]  hold;
		logic [11:0] io;
		logic [7:0]  st;
		logic [3:0]  mux;
		logic [3:0]  b1;
		logic [15:0] db;
		logic        da;
		logic [3:0]  flags;
	} case_row_t;

	`include "switch_app_cases.svh"

	localparam int timeout_cycles = num_cases * (settle_cycles + 10) + 50;

	logic        xclk;
	logic        reset;
	logic        write_qualified;
	logic        read_qualified;
	bus_addr_t   ab;
	bus_word_u   db_in;
	logic [15:0] db_out;
	logic        data_avail;
	logic [11:0] io_pin_switches;
	logic [7:0]  self_test_switches;
	logic [3:0]  loopback_mux;
	logic [3:0]  anlg_in_b1_switches;

	int          errors;
	logic [31:0] lfsr;
	logic [3:0]  b1_nib;
	logic [3:0]  st_nib;
	case_row_t   row;
	logic [15:0] data;
	logic [3:0]  exp_b1;
	logic [7:0]  exp_st;
	logic [15:0] exp_db;

	switch_app_top #(.settle_cycles(settle_cycles)) dut0 (
		.xclk                (xclk),
		.reset               (reset),
		.write_qualified     (write_qualified),
		.read_qualified      (read_qualified),
		.ab                  (ab),
		.db_in               (db_in),
		.db_out              (db_out),
		.data_avail          (data_avail),
		.io_pin_switches     (io_pin_switches),
		.self_test_switches  (self_test_switches),
		.loopback_mux        (loopback_mux),
		.anlg_in_b1_switches (anlg_in_b1_switches)
	);

	// 100 ns period
	initial xclk = 1'b0;
	always #50 xclk = ~xclk;

	////////////////////
	// Helpers
	////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic draw_nibble(output logic [3:0] nib);
		nib = '0;
		for (int i = 0; i < 4; i++) begin
			lfsr = next_lfsr(lfsr);
			nib  = {nib[2:0], lfsr[0]};
		end
	endtask

	// Only the lowest requested switch may close
	function automatic logic [3:0] lowest_set(input logic [3:0] v);
		logic [3:0] r;
		r = '0;
		for (int i = 3; i >= 0; i--) begin
			if (v[i])
				r = 4'b0001 << i;
		end
		return r;
	endfunction

	task automatic compare_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("FAILED at time %0t: %s expected 0x%h, got 0x%h",
				$time, name, expected, actual);
		end
	endtask

	////////////////////
	// Exclusion monitor
	////////////////////

	// Pairs must never be seen closed together
	always @(negedge xclk) begin
		if (reset) begin
			compare_value("pin6_with_mux_en", 16'h0,
				16'(io_pin_switches[6] & loopback_mux[3]));
			compare_value("diff_pins_with_diff_loop", 16'h0,
				16'((|io_pin_switches[11:10]) & self_test_switches[0]));
		end
	end

	// Watchdog
	initial begin
		repeat (timeout_cycles) @(posedge xclk);
		$display("Run timed out after %0d clock cycles before the table was done",
			timeout_cycles);
		$display("Error count %0d", errors);
		$display("Finished with errors");
		$finish;
	end

	////////////////////
	// Table walk
	////////////////////

	initial begin
		errors          = 0;
		lfsr            = 32'h2d52_6e62;
		b1_nib          = '0;
		st_nib          = '0;
		reset           = 1'b0;
		write_qualified = 1'b0;
		read_qualified  = 1'b0;
		ab              = '0;
		db_in           = '0;
		repeat (5) @(posedge xclk);
		reset <= 1'b1;

		for (int i = 0; i < num_cases; i++) begin
			row  = cases[i];
			data = row.data;
			// Random nibble lands in the group's field
			if (row.rnd == rnd_b1) begin
				draw_nibble(b1_nib);
				data[3:0] = b1_nib;
			end else if (row.rnd == rnd_st) begin
				draw_nibble(st_nib);
				data[7:4] = st_nib;
			end

			@(posedge xclk);
			ab              <= row.addr;
			db_in           <= data;
			write_qualified <= (row.op == op_write);
			read_qualified  <= (row.op == op_read);
			// Bus edge, strobes drop afterwards
			@(posedge xclk);
			write_qualified <= 1'b0;
			read_qualified  <= 1'b0;
			repeat (row.hold) @(posedge xclk);
			@(negedge xclk);

			// Fold in the expected winner of a random request
			exp_b1 = row.b1;
			exp_st = row.st;
			exp_db = row.db;
			if (row.flags[0])
				exp_b1 = exp_b1 | lowest_set(b1_nib);
			if (row.flags[1])
				exp_st[7:4] = exp_st[7:4] | lowest_set(st_nib);
			if (row.flags[2])
				exp_db[3:0] = exp_db[3:0] | lowest_set(b1_nib);
			if (row.flags[3])
				exp_db[7:4] = exp_db[7:4] | lowest_set(st_nib);

			compare_value("io_pin_switches", 16'(row.io), 16'(io_pin_switches));
			compare_value("self_test_switches", 16'(exp_st), 16'(self_test_switches));
			compare_value("loopback_mux", 16'(row.mux), 16'(loopback_mux));
			compare_value("anlg_in_b1_switches", 16'(exp_b1), 16'(anlg_in_b1_switches));
			compare_value("db_out", exp_db, db_out);
			compare_value("data_avail", 16'(row.da), 16'(data_avail));
		end

		$display("Table done with %0d errors", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
rtl/switch_pkg.sv
rtl/bus_write_decode.sv
rtl/one_hot_bbm.sv
rtl/exclusive_pair_bbm.sv
rtl/switch_readback.sv
rtl/switch_app_top.sv
verification/switch_app_tb.sv

// ==== Bender.yml ====
package:
  name: switch_app

sources:
  - files:
      - rtl/switch_pkg.sv
      - rtl/bus_write_decode.sv
      - rtl/one_hot_bbm.sv
      - rtl/exclusive_pair_bbm.sv
      - rtl/switch_readback.sv
      - rtl/switch_app_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/switch_app_tb.sv
